/* list.f */
verilog/streamer_pkg.sv
verilog/stream_fifo.sv
verilog/addr_gen.sv
verilog/sink_streamer.sv
verilog/mem_arbiter.sv
verilog/sink_cluster_top.sv
verification/tb_clock.sv
verification/tb_sink_cluster.sv

/* run_sim.sh */
#!/bin/sh
# build and run the sink cluster testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert -f list.f \
  --top-module tb_sink_cluster -Mdir obj_dir -o sim_tb
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

./obj_dir/sim_tb > "$log" 2>&1
status=$?
cat "$log"

# the log decides, the exit status only backs it up
if grep -q "Simulation failed" "$log"; then
  exit 1
fi
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi
if ! grep -q "Simulation passed" "$log"; then
  echo "no pass line found in $log"
  exit 1
fi
exit 0

/* verification/tb_sink_cluster.sv */
module tb_sink_cluster;

  import streamer_pkg::*;

  localparam int total_stores = 8 + 3 * 6 + 12 + 14 + 24 + 18; // all stores queued
  localparam int cycle_limit  = 4 * total_stores + 200;
  localparam int max_st       = 128; // expected stores kept per port

  logic                              clk_i;
  logic                              rst_ni         = 1'b0;
  logic                              clear_i        = 1'b0;
  logic                              enable_i       = 1'b1;
  logic [n_ports-1:0]                job_valid_i    = '0;
  logic [n_ports-1:0]                job_ready_o;
  job_t [n_ports-1:0]                job_i          = '0;
  logic [n_ports-1:0]                stream_valid_i = '0;
  logic [n_ports-1:0][stream_dw-1:0] stream_data_i  = '0;
  logic [n_ports-1:0][stream_sw-1:0] stream_strb_i  = '0;
  logic [n_ports-1:0]                stream_ready_o, done_o;
  logic                              mem_req_o;
  logic [addr_w-1:0]                 mem_addr_o;
  logic [mem_dw-1:0]                 mem_wdata_o;
  logic [mem_bw-1:0]                 mem_be_o;
  logic                              mem_gnt_i = 1'b0;

  logic [addr_w-1:0]  exp_baddr [n_ports][max_st]; // byte address of each store
  int                 tail [n_ports]     = '{0, 0}; // stores queued
  int                 head [n_ports]     = '{0, 0}; // stores granted
  int                 sent [n_ports]     = '{0, 0}; // beat on the stream
  int                 job_end [n_ports][16];        // store index after each job
  int                 njobs [n_ports]    = '{0, 0};
  int                 done_idx [n_ports] = '{0, 0}; // next job expected to finish
  logic [7:0]         exp_bytes [logic [31:0]];
  logic [7:0]         mem_model [logic [31:0]];     // written memory bytes
  logic [15:0]        lfsr_q    = 16'd3119;
  logic               cleared_q = 1'b0;             // quiet after clear
  logic [n_ports-1:0] last_gnt  = '0;               // last grant while both request
  int                 stores    = 0;                // stores seen at the memory port
  int                 cycles    = 0;

  tb_clock #(.period(20)) i_clock (.clk_o(clk_i));

  sink_cluster_top uut (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .clear_i        ( clear_i        ),
    .enable_i       ( enable_i       ),
    .job_valid_i    ( job_valid_i    ),
    .job_i          ( job_i          ),
    .job_ready_o    ( job_ready_o    ),
    .stream_valid_i ( stream_valid_i ),
    .stream_data_i  ( stream_data_i  ),
    .stream_strb_i  ( stream_strb_i  ),
    .stream_ready_o ( stream_ready_o ),
    .done_o         ( done_o         ),
    .mem_req_o      ( mem_req_o      ),
    .mem_addr_o     ( mem_addr_o     ),
    .mem_wdata_o    ( mem_wdata_o    ),
    .mem_be_o       ( mem_be_o       ),
    .mem_gnt_i      ( mem_gnt_i      )
  );

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]}; // taps 16 14 13 11
  endfunction

  // beat contents from port and beat index
  function automatic logic [31:0] beat_data(input int p, input int k);
    return (32'(k) * 32'h0103_0507 + 32'h0a0b_0c0d) ^ {8'(p * 8'h5a), 24'h0};
  endfunction

  function automatic logic [3:0] beat_strb(input int k);
    return (k % 5 == 3) ? 4'b0110 : 4'b1111; // some partial beats
  endfunction

  wire [n_ports-1:0] port_req = uut.port_req; // streamer side of the arbiter
  wire [n_ports-1:0] port_gnt = uut.port_gnt;
  wire               fire     = mem_req_o & mem_gnt_i;
  wire               both_req = &port_req;
  wire               gp       = port_gnt[1]; // granted port
  wire [addr_w-1:0]  exp_ba   = exp_baddr[gp][head[gp] % max_st];
  wire [1:0]         exp_off  = exp_ba[1:0];
  wire [addr_w-1:0]  exp_addr = {exp_ba[addr_w-1:2], 2'b00};
  wire [mem_bw-1:0]  exp_be   = {4'b0000, beat_strb(head[gp])} << exp_off;
  wire [mem_dw-1:0]  exp_data = {32'h0, beat_data(int'(gp), head[gp])} << {exp_off, 3'b000};
  logic [mem_dw-1:0] exp_mask;

  for (genvar i = 0; i < mem_bw; i++) begin : g_mask
    assign exp_mask[8*i +: 8] = {8{exp_be[i]}}; // only enabled bytes compared
  end

  task automatic abort_run();
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic value_error(input string name, input logic [63:0] exp, input logic [63:0] act);
    $display("[FAIL] time %0t: %s expected 0x%0h, got 0x%0h", $time, name, exp, act);
    abort_run();
  endtask

  task automatic plain_error(input string what);
    $display("error at time %0t: %s", $time, what);
    abort_run();
  endtask

  // address rule: base + row * d1_stride + col * d0_stride
  task automatic queue_job(input int p, input logic [31:0] base, input int d0_len,
                           input int d0_str, input int d1_len, input int d1_str);
    job_t        j;
    logic [31:0] a;
    logic [31:0] d;
    logic [3:0]  s;
    j.base      = base;
    j.d0_len    = 16'(d0_len);
    j.d0_stride = 16'(d0_str);
    j.d1_len    = 16'(d1_len);
    j.d1_stride = 16'(d1_str);
    @(negedge clk_i); // model updated away from the edge
    for (int r = 0; r < d1_len; r++) begin
      for (int c = 0; c < d0_len; c++) begin
        a = base + 32'(r * d1_str + c * d0_str);
        d = beat_data(p, tail[p]);
        s = beat_strb(tail[p]);
        exp_baddr[p][tail[p] % max_st] = a;
        for (int i = 0; i < 4; i++) begin
          if (s[i]) exp_bytes[a + 32'(i)] = d[8*i +: 8]; // shifted by the byte address
        end
        tail[p] = tail[p] + 1;
      end
    end
    job_end[p][njobs[p] % 16] = tail[p];
    njobs[p] = njobs[p] + 1;
    @(posedge clk_i);
    job_valid_i[p] <= 1'b1;
    job_i[p]       <= j;
    do @(posedge clk_i); while (!job_ready_o[p]); // held until taken
    job_valid_i[p] <= 1'b0;
  endtask

  task automatic wait_jobs(input int p);
    while (done_idx[p] < njobs[p]) @(negedge clk_i);
  endtask

  task automatic clear_model();
    @(negedge clk_i);
    exp_bytes.delete();
    mem_model.delete();
  endtask

  task automatic check_memory();
    assert (mem_model.num() == exp_bytes.num())
      else value_error("written byte count", 64'(exp_bytes.num()), 64'(mem_model.num()));
    foreach (exp_bytes[a]) begin
      assert (mem_model.exists(a)) else plain_error($sformatf("byte 0x%0h never written", a));
      assert (mem_model[a] == exp_bytes[a])
        else value_error($sformatf("mem[0x%0h]", a), 64'(exp_bytes[a]), 64'(mem_model[a]));
    end
  endtask

  // stream sources, one beat each until accepted
  always @(posedge clk_i) begin : drive_streams
    int nxt;
    for (int p = 0; p < n_ports; p++) begin
      nxt = sent[p] + ((stream_valid_i[p] && stream_ready_o[p]) ? 1 : 0);
      if (clear_i) begin
        sent[p]           <= tail[p]; // pending beats dropped
        stream_valid_i[p] <= 1'b0;
      end else begin
        sent[p]           <= nxt;
        stream_valid_i[p] <= (nxt < tail[p]);
        stream_data_i[p]  <= beat_data(p, nxt);
        stream_strb_i[p]  <= beat_strb(nxt);
      end
    end
  end

  // byte memory with random grants
  always @(posedge clk_i) begin : memory
    logic b0;
    if (fire) begin
      for (int i = 0; i < mem_bw; i++) begin
        if (mem_be_o[i]) mem_model[mem_addr_o + 32'(i)] = mem_wdata_o[8*i +: 8];
      end
      stores = stores + 1;
    end
    lfsr_q    = lfsr_next(lfsr_q);
    b0        = lfsr_q[0];
    lfsr_q    = lfsr_next(lfsr_q);
    mem_gnt_i <= b0 | lfsr_q[0]; // about three grants in four
  end

  always @(posedge clk_i) begin : scoreboard
    for (int p = 0; p < n_ports; p++) begin
      if (clear_i) begin
        head[p]     <= tail[p];
        done_idx[p] <= njobs[p]; // aborted job never reports
      end else begin
        if (fire && port_gnt[p]) head[p] <= head[p] + 1;
        if (done_o[p]) done_idx[p] <= done_idx[p] + 1;
      end
    end
    if (clear_i) cleared_q <= 1'b1;
    else if (|job_valid_i) cleared_q <= 1'b0;
    if (clear_i || !both_req) last_gnt <= '0;
    else if (fire) last_gnt <= port_gnt;
  end

  always @(posedge clk_i) begin : watchdog
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("timeout: run exceeded %0d cycles", cycle_limit);
      abort_run();
    end
  end

  assert property (@(posedge clk_i) disable iff (!rst_ni) mem_req_o |-> mem_addr_o[1:0] == 2'b00)
    else value_error("mem_addr_o[1:0]", 64'd0, 64'($sampled(mem_addr_o[1:0])));
  assert property (@(posedge clk_i) disable iff (!rst_ni) fire |-> head[gp] < tail[gp])
    else plain_error("store granted with no store pending on that port");
  assert property (@(posedge clk_i) disable iff (!rst_ni) fire |-> mem_addr_o == exp_addr)
    else value_error("mem_addr_o", 64'($sampled(exp_addr)), 64'($sampled(mem_addr_o)));
  assert property (@(posedge clk_i) disable iff (!rst_ni) fire |-> mem_be_o == exp_be)
    else value_error("mem_be_o", 64'($sampled(exp_be)), 64'($sampled(mem_be_o)));
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    fire |-> (mem_wdata_o & exp_mask) == (exp_data & exp_mask))
    else value_error("mem_wdata_o", $sampled(exp_data & exp_mask),
                     $sampled(mem_wdata_o & exp_mask));
  // round robin, no port twice in a row while both wait
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (fire && both_req && last_gnt != '0) |-> port_gnt != last_gnt)
    else value_error("port_gnt", 64'($sampled(~last_gnt)), 64'($sampled(port_gnt)));
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    cleared_q |-> (!mem_req_o && done_o == '0 && job_ready_o == '1))
    else plain_error("store, done or full job queue after clear");

  for (genvar g = 0; g < n_ports; g++) begin : g_port
    // store index the next done pulse must see
    wire [31:0] end_idx = (done_idx[g] < njobs[g]) ? 32'(job_end[g][done_idx[g] % 16]) : '1;
    assert property (@(posedge clk_i) disable iff (!rst_ni) done_o[g] |-> head[g] == end_idx)
      else value_error($sformatf("granted stores at done_o[%0d]", g),
                       64'($sampled(end_idx)), 64'($sampled(head[g])));
    // beat taken only together with its granted store
    assert property (@(posedge clk_i) disable iff (!rst_ni)
      (stream_valid_i[g] && stream_ready_o[g]) == (fire && port_gnt[g]))
      else value_error($sformatf("stream_ready_o[%0d]", g),
                       64'($sampled(fire && port_gnt[g])), 64'($sampled(stream_ready_o[g])));
  end

  initial begin : stimulus
    int start;
    int first;
    repeat (16) @(posedge clk_i);
    rst_ni <= 1'b1;
    clear_model(); // aligned single row
    queue_job(0, 32'h100, 8, 4, 1, 0);
    wait_jobs(0);
    check_memory();
    for (int off = 1; off < 4; off++) begin
      clear_model(); // byte offset 1 to 3
      queue_job(0, 32'h200 + 32'(off * 'h100 + off), 6, 4, 1, 0);
      wait_jobs(0);
      check_memory();
    end
    clear_model(); // three rows with outer stride
    queue_job(0, 32'h1000, 4, 4, 3, 'h40);
    wait_jobs(0);
    check_memory();
    clear_model(); // two jobs back to back
    queue_job(0, 32'h2000, 8, 4, 1, 0);
    queue_job(0, 32'h2102, 3, 8, 2, 'h20);
    @(negedge clk_i);
    assert (!job_ready_o[0]) else value_error("job_ready_o[0]", 64'd0, 64'(job_ready_o[0]));
    wait_jobs(0);
    check_memory();
    clear_model(); // both ports under random stalls
    first = stores;
    queue_job(0, 32'h3000, 6, 4, 2, 'h40);
    queue_job(1, 32'h5001, 4, 8, 3, 'h80);
    wait_jobs(0);
    wait_jobs(1);
    assert (stores - first == 6 * 2 + 4 * 3)
      else value_error("stores at mem port", 64'(6 * 2 + 4 * 3), 64'(stores - first));
    check_memory();
    start = tail[1]; // clear in mid job
    queue_job(1, 32'h6000, 16, 4, 1, 0);
    while (head[1] < start + 4) @(negedge clk_i);
    @(posedge clk_i);
    clear_i <= 1'b1;
    @(posedge clk_i);
    clear_i <= 1'b0;
    repeat (5) @(posedge clk_i);
    clear_model(); // recovery job after clear
    queue_job(1, 32'h6800, 2, 4, 1, 0);
    wait_jobs(1);
    check_memory();
    @(negedge clk_i);
    $display("Simulation passed");
    $finish;
  end

endmodule

/* verification/tb_clock.sv */
module tb_clock #(
  parameter int period = 20
) (
  output logic clk_o
);

  logic clk_q = 1'b0; // starts low

  // free running, half period per phase
  always #(period / 2) clk_q = ~clk_q;

  assign clk_o = clk_q;

endmodule

/* verilog/sink_cluster_top.sv */
module sink_cluster_top (
  input  logic                                                          clk_i,
  input  logic                                                          rst_ni,
  input  logic                                                          clear_i,
  input  logic                                                          enable_i,
  // per-port job queues
  input  logic [streamer_pkg::n_ports-1:0]                              job_valid_i,
  input  streamer_pkg::job_t [streamer_pkg::n_ports-1:0]                job_i,
  output logic [streamer_pkg::n_ports-1:0]                              job_ready_o,
  // per-port data streams
  input  logic [streamer_pkg::n_ports-1:0]                              stream_valid_i,
  input  logic [streamer_pkg::n_ports-1:0][streamer_pkg::stream_dw-1:0] stream_data_i,
  input  logic [streamer_pkg::n_ports-1:0][streamer_pkg::stream_sw-1:0] stream_strb_i,
  output logic [streamer_pkg::n_ports-1:0]                              stream_ready_o,
  output logic [streamer_pkg::n_ports-1:0]                              done_o,
  // shared memory write port
  output logic                                                          mem_req_o,
  output logic [streamer_pkg::addr_w-1:0]                               mem_addr_o,
  output logic [streamer_pkg::mem_dw-1:0]                               mem_wdata_o,
  output logic [streamer_pkg::mem_bw-1:0]                               mem_be_o,
  input  logic                                                          mem_gnt_i
);

  import streamer_pkg::*;

  // streamer side of the arbiter
  logic [n_ports-1:0]             port_req, port_gnt;
  logic [n_ports-1:0][addr_w-1:0] port_addr;
  logic [n_ports-1:0][mem_dw-1:0] port_data;
  logic [n_ports-1:0][mem_bw-1:0] port_be;

  for (genvar p = 0; p < n_ports; p++) begin : gen_sink
    sink_streamer i_sink (
      .clk_i          ( clk_i             ),
      .rst_ni         ( rst_ni            ),
      .clear_i        ( clear_i           ),
      .enable_i       ( enable_i          ),
      .job_valid_i    ( job_valid_i[p]    ),
      .job_i          ( job_i[p]          ),
      .job_ready_o    ( job_ready_o[p]    ),
      .stream_valid_i ( stream_valid_i[p] ),
      .stream_data_i  ( stream_data_i[p]  ),
      .stream_strb_i  ( stream_strb_i[p]  ),
      .stream_ready_o ( stream_ready_o[p] ),
      .req_o          ( port_req[p]       ),
      .addr_o         ( port_addr[p]      ),
      .data_o         ( port_data[p]      ),
      .be_o           ( port_be[p]        ),
      .gnt_i          ( port_gnt[p]       ),
      .done_o         ( done_o[p]         )
    );
  end

  // round robin onto the single port
  mem_arbiter i_arbiter (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .clear_i     ( clear_i     ),
    .req_i       ( port_req    ),
    .addr_i      ( port_addr   ),
    .data_i      ( port_data   ),
    .be_i        ( port_be     ),
    .gnt_o       ( port_gnt    ),
    .mem_req_o   ( mem_req_o   ),
    .mem_addr_o  ( mem_addr_o  ),
    .mem_wdata_o ( mem_wdata_o ),
    .mem_be_o    ( mem_be_o    ),
    .mem_gnt_i   ( mem_gnt_i   )
  );

endmodule

/* verilog/mem_arbiter.sv */
module mem_arbiter (
  input  logic                                                       clk_i,
  input  logic                                                       rst_ni,
  input  logic                                                       clear_i,
  input  logic [streamer_pkg::n_ports-1:0]                           req_i,
  input  logic [streamer_pkg::n_ports-1:0][streamer_pkg::addr_w-1:0] addr_i,
  input  logic [streamer_pkg::n_ports-1:0][streamer_pkg::mem_dw-1:0] data_i,
  input  logic [streamer_pkg::n_ports-1:0][streamer_pkg::mem_bw-1:0] be_i,
  output logic [streamer_pkg::n_ports-1:0]                           gnt_o,
  output logic                                                       mem_req_o,
  output logic [streamer_pkg::addr_w-1:0]                            mem_addr_o,
  output logic [streamer_pkg::mem_dw-1:0]                            mem_wdata_o,
  output logic [streamer_pkg::mem_bw-1:0]                            mem_be_o,
  input  logic                                                       mem_gnt_i
);

  import streamer_pkg::*;

  logic [port_sel_w-1:0] ptr_q;   // highest priority requester
  logic [port_sel_w-1:0] win_idx;
  logic                  win_valid;

  // first requester at or after the pointer
  always_comb begin : pick
    int cand;
    win_valid = 1'b0;
    win_idx   = '0;
    for (int i = 0; i < int'(n_ports); i++) begin
      cand = (int'(ptr_q) + i) % int'(n_ports);
      if (!win_valid && req_i[cand]) begin
        win_valid = 1'b1;
        win_idx   = cand[port_sel_w-1:0];
      end
    end
  end

  assign mem_req_o   = win_valid;
  assign mem_addr_o  = addr_i[win_idx];
  assign mem_wdata_o = data_i[win_idx];
  assign mem_be_o    = be_i[win_idx];

  // grant goes back to the winner only
  always_comb begin
    gnt_o          = '0;
    gnt_o[win_idx] = win_valid & mem_gnt_i;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) ptr_q <= '0;
    else if (clear_i) ptr_q <= '0;
    else if (win_valid && mem_gnt_i) begin // move past winner
      if (int'(win_idx) == int'(n_ports) - 1) ptr_q <= '0;
      else ptr_q <= win_idx + 1'b1;
    end
  end

endmodule

/* verilog/sink_streamer.sv */
module sink_streamer (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  logic                               clear_i,
  input  logic                               enable_i,
  // job queue input
  input  logic                               job_valid_i,
  input  streamer_pkg::job_t                 job_i,
  output logic                               job_ready_o,
  // data stream input
  input  logic                               stream_valid_i,
  input  logic [streamer_pkg::stream_dw-1:0] stream_data_i,
  input  logic [streamer_pkg::stream_sw-1:0] stream_strb_i,
  output logic                               stream_ready_o,
  // store request
  output logic                               req_o,
  output logic [streamer_pkg::addr_w-1:0]    addr_o,
  output logic [streamer_pkg::mem_dw-1:0]    data_o,
  output logic [streamer_pkg::mem_bw-1:0]    be_o,
  input  logic                               gnt_i,
  output logic                               done_o
);

  import streamer_pkg::*;

  streamer_state_t   cs, ns;
  job_t              job_head;                     // next job to run
  logic              job_pop_valid, job_pop_ready, job_empty;
  logic              gen_en, presample, gen_done;
  logic              addr_push_valid, addr_push_ready;
  logic [addr_w-1:0] addr_push_data, addr_pop_data;
  logic              addr_pop_valid, addr_pop_ready;
  logic [1:0]        byte_off;                     // misalignment in bytes
  logic [cnt_w-1:0]  store_cnt_q, tot_len_q;
  logic              store_fire, store_cnt_clr;

  stream_fifo #(
    .depth     ( job_fifo_depth ),
    .payload_t ( job_t          )
  ) i_job_fifo (
    .clk_i        ( clk_i         ),
    .rst_ni       ( rst_ni        ),
    .clear_i      ( clear_i       ),
    .push_valid_i ( job_valid_i   ),
    .push_data_i  ( job_i         ),
    .push_ready_o ( job_ready_o   ), // low while full
    .pop_valid_o  ( job_pop_valid ),
    .pop_data_o   ( job_head      ),
    .pop_ready_i  ( job_pop_ready ),
    .empty_o      ( job_empty     )
  );

  addr_gen i_addr_gen (
    .clk_i        ( clk_i           ),
    .rst_ni       ( rst_ni          ),
    .clear_i      ( clear_i         ),
    .enable_i     ( gen_en          ),
    .presample_i  ( presample       ),
    .job_i        ( job_head        ),
    .addr_valid_o ( addr_push_valid ),
    .addr_ready_i ( addr_push_ready ),
    .addr_o       ( addr_push_data  ),
    .done_o       ( gen_done        )
  );

  // decouples address generation from the data stream
  stream_fifo #(
    .depth     ( addr_fifo_depth      ),
    .payload_t ( logic [addr_w-1:0]   )
  ) i_addr_fifo (
    .clk_i        ( clk_i           ),
    .rst_ni       ( rst_ni          ),
    .clear_i      ( clear_i         ),
    .push_valid_i ( addr_push_valid ),
    .push_data_i  ( addr_push_data  ),
    .push_ready_o ( addr_push_ready ),
    .pop_valid_o  ( addr_pop_valid  ),
    .pop_data_o   ( addr_pop_data   ),
    .pop_ready_i  ( addr_pop_ready  ),
    .empty_o      (                 )
  );

  // shift beat into place, upper word catches the spill
  assign byte_off = addr_pop_data[1:0];
  assign data_o   = mem_dw'(stream_data_i) << {byte_off, 3'b000};
  assign be_o     = mem_bw'(stream_strb_i) << byte_off;
  assign addr_o   = {addr_pop_data[addr_w-1:2], 2'b00}; // word aligned

  assign req_o          = (cs != st_idle) & stream_valid_i & addr_pop_valid;
  assign store_fire     = req_o & gnt_i;
  assign stream_ready_o = ~stream_valid_i | store_fire;
  assign addr_pop_ready = stream_valid_i & stream_ready_o; // one address per beat

  // stores expected for the running job
  always_ff @(posedge clk_i) begin
    if (enable_i && presample) tot_len_q <= job_head.d0_len * job_head.d1_len;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) store_cnt_q <= '0;
    else if (clear_i || store_cnt_clr) store_cnt_q <= '0;
    else if (store_fire) store_cnt_q <= store_cnt_q + 1'b1; // granted stores
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) cs <= st_idle;
    else if (clear_i) cs <= st_idle;
    else if (enable_i) cs <= ns;
  end

  always_comb begin
    ns            = cs;
    gen_en        = 1'b0;
    presample     = 1'b0;
    job_pop_ready = 1'b0;
    store_cnt_clr = 1'b0;
    done_o        = 1'b0;
    case (cs)
      st_idle: begin
        if (job_valid_i || !job_empty) ns = st_presample; // job arriving or queued
      end
      st_presample: begin
        gen_en    = 1'b1;
        presample = 1'b1;
        ns        = st_working;
      end
      st_working: begin
        gen_en = 1'b1;
        if (gen_done) begin
          job_pop_ready = 1'b1; // head job fully addressed
          ns            = st_draining;
        end
      end
      st_draining: begin
        if (enable_i && store_cnt_q == tot_len_q) begin
          done_o        = 1'b1;
          store_cnt_clr = 1'b1;
          ns            = job_pop_valid ? st_presample : st_idle;
        end
      end
      default: ns = st_idle;
    endcase
  end

endmodule

/* verilog/addr_gen.sv */
module addr_gen (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            clear_i,
  input  logic                            enable_i,
  input  logic                            presample_i,
  input  streamer_pkg::job_t              job_i,
  output logic                            addr_valid_o,
  input  logic                            addr_ready_i,
  output logic [streamer_pkg::addr_w-1:0] addr_o,
  output logic                            done_o
);

  import streamer_pkg::*;

  job_t              job_q;              // active job
  logic              busy_q;             // addresses left to emit
  logic [cnt_w-1:0]  d0_cnt_q, d1_cnt_q; // inner and outer position
  logic [addr_w-1:0] d0_off_q, d1_off_q; // byte offsets
  logic              push;
  logic              row_end, last;

  // emit while busy, one address per accepted cycle
  assign addr_valid_o = enable_i & busy_q;
  assign addr_o       = job_q.base + d1_off_q + d0_off_q;
  assign push         = addr_valid_o & addr_ready_i;

  assign row_end = (d0_cnt_q == job_q.d0_len - 1'b1);
  assign last    = row_end & (d1_cnt_q == job_q.d1_len - 1'b1);
  assign done_o  = push & last; // same cycle as the last push

  // job snapshot taken in presample
  always_ff @(posedge clk_i) begin
    if (enable_i && presample_i) job_q <= job_i;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q   <= 1'b0;
      d0_cnt_q <= '0;
      d1_cnt_q <= '0;
      d0_off_q <= '0;
      d1_off_q <= '0;
    end else if (clear_i) begin
      busy_q   <= 1'b0;
      d0_cnt_q <= '0;
      d1_cnt_q <= '0;
      d0_off_q <= '0;
      d1_off_q <= '0;
    end else if (enable_i) begin
      if (presample_i) begin // restart at base
        busy_q   <= 1'b1;
        d0_cnt_q <= '0;
        d1_cnt_q <= '0;
        d0_off_q <= '0;
        d1_off_q <= '0;
      end else if (push) begin
        if (last) busy_q <= 1'b0; // quiet until next presample
        if (row_end) begin
          // next row, outer step
          d0_cnt_q <= '0;
          d0_off_q <= '0;
          d1_cnt_q <= d1_cnt_q + 1'b1;
          d1_off_q <= d1_off_q + addr_w'(job_q.d1_stride);
        end else begin
          d0_cnt_q <= d0_cnt_q + 1'b1;
          d0_off_q <= d0_off_q + addr_w'(job_q.d0_stride); // inner step
        end
      end
    end
  end

endmodule

/* verilog/stream_fifo.sv */
module stream_fifo #(
  parameter int unsigned depth     = 2,
  parameter type         payload_t = logic [31:0]
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     clear_i,
  input  logic     push_valid_i,
  input  payload_t push_data_i,
  output logic     push_ready_o,
  output logic     pop_valid_o,
  output payload_t pop_data_o,
  input  logic     pop_ready_i,
  output logic     empty_o
);

  payload_t                     mem_q [depth]; // storage, no reset
  logic [$clog2(depth)-1:0]     wr_ptr_q, rd_ptr_q;
  logic [$clog2(depth+1)-1:0]   count_q;
  logic                         full, push, pop;

  assign full         = (int'(count_q) == int'(depth));
  assign empty_o      = (count_q == '0);
  assign pop_valid_o  = ~empty_o;
  assign pop_data_o   = mem_q[rd_ptr_q];
  assign push_ready_o = ~full | pop_ready_i; // a pop frees a slot when full
  assign push         = push_valid_i & push_ready_o;
  assign pop          = pop_valid_o & pop_ready_i;

  always_ff @(posedge clk_i) begin
    if (push) mem_q[wr_ptr_q] <= push_data_i;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (clear_i) begin // flush everything
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        if (int'(wr_ptr_q) == int'(depth) - 1) wr_ptr_q <= '0; // wrap
        else wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        if (int'(rd_ptr_q) == int'(depth) - 1) rd_ptr_q <= '0;
        else rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q; // both or neither
      endcase
    end
  end

endmodule

/* verilog/streamer_pkg.sv */
package streamer_pkg;

  // datapath widths
  localparam int unsigned addr_w    = 32;             // byte address
  localparam int unsigned stream_dw = 32;             // incoming stream word
  localparam int unsigned stream_sw = stream_dw / 8;  // stream strobes
  localparam int unsigned mem_dw    = stream_dw + 32; // extra word for misaligned shift
  localparam int unsigned mem_bw    = mem_dw / 8;     // byte enables
  localparam int unsigned cnt_w     = 16;             // length and store counters

  // queue sizing
  localparam int unsigned job_fifo_depth  = 2;
  localparam int unsigned addr_fifo_depth = 2;

  // requesters sharing the memory port
  localparam int unsigned n_ports    = 2;
  localparam int unsigned port_sel_w = (n_ports > 1) ? $clog2(n_ports) : 1;

  // one store job, two-level stride pattern
  typedef struct packed {
    logic [addr_w-1:0] base;      // first byte address
    logic [cnt_w-1:0]  d0_len;    // stores per row
    logic [cnt_w-1:0]  d0_stride; // byte step inside a row
    logic [cnt_w-1:0]  d1_len;    // number of rows
    logic [cnt_w-1:0]  d1_stride; // byte step between rows
  } job_t;

  // streamer control FSM
  typedef enum logic [1:0] {
    st_idle,
    st_presample, // generator loads head job
    st_working,   // addresses being produced
    st_draining   // waiting for the last grants
  } streamer_state_t;

endpackage
